//--- idc_pkg.sv
`default_nettype none

package idc_pkg;

    //////////////////////////////////////////////////
    // Field and datapath widths
    //////////////////////////////////////////////////
    typedef logic [31:0] instr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  alu_op_t;
    // 00 word, 01 signed byte, 10 signed half
    typedef logic [1:0]  sem_ctrl_t;

    // Primary opcodes
    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_J     = 6'b000010;
    localparam opcode_t OP_JAL   = 6'b000011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_BNE   = 6'b000101;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_LB    = 6'b100000;
    localparam opcode_t OP_LH    = 6'b100001;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;

    // R-type function codes
    localparam funct_t FN_SLL = 6'b000000;
    localparam funct_t FN_JR  = 6'b001000;
    localparam funct_t FN_ADD = 6'b100000;
    localparam funct_t FN_SUB = 6'b100010;
    localparam funct_t FN_AND = 6'b100100;
    localparam funct_t FN_OR  = 6'b100101;
    localparam funct_t FN_SLT = 6'b101010;
    localparam funct_t FN_SAD = 6'b111000;

    // Operation codes seen by the EX stage ALU
    localparam alu_op_t ALU_OP_NOP  = 6'b000000;
    localparam alu_op_t ALU_OP_ADD  = 6'b000001;
    localparam alu_op_t ALU_OP_SUB  = 6'b000010;
    localparam alu_op_t ALU_OP_AND  = 6'b000011;
    localparam alu_op_t ALU_OP_OR   = 6'b000100;
    localparam alu_op_t ALU_OP_SLT  = 6'b000101;
    localparam alu_op_t ALU_OP_SLL  = 6'b000110;
    localparam alu_op_t ALU_OP_SAD  = 6'b000111;
    localparam alu_op_t ALU_OP_LINK = 6'b001110;

endpackage

`default_nettype wire

//--- control_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
    input  idc_pkg::opcode_t   opcode,
    input  idc_pkg::funct_t    funct,
    output logic               alu_src,
    output logic               reg_dst,
    output logic               reg_write,
    output logic               mem_read,
    output logic               mem_write,
    output logic               mem_to_reg,
    output logic               alu_sft,
    output logic               zero_src,
    output logic               branch,
    output logic               jal_src,
    output logic               jzero_src,
    output logic               jr_src,
    output logic               sad_op,
    output idc_pkg::alu_op_t   alu_op,
    output idc_pkg::sem_ctrl_t sem_ctrl
);

    import idc_pkg::*;

    always_comb begin
        // Start from the bubble set where unknown codes stay
        alu_src    = 1'b0;
        reg_dst    = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        alu_sft    = 1'b0;
        zero_src   = 1'b0;
        branch     = 1'b0;
        jal_src    = 1'b1;
        jzero_src  = 1'b0;
        jr_src     = 1'b0;
        sad_op     = 1'b0;
        alu_op     = ALU_OP_NOP;
        sem_ctrl   = 2'b00;

        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT: begin
                        reg_dst   = 1'b1;
                        reg_write = 1'b1;
                        case (funct)
                            FN_ADD:  alu_op = ALU_OP_ADD;
                            FN_SUB:  alu_op = ALU_OP_SUB;
                            FN_AND:  alu_op = ALU_OP_AND;
                            FN_OR:   alu_op = ALU_OP_OR;
                            default: alu_op = ALU_OP_SLT;
                        endcase
                    end
                    FN_SLL: begin
                        reg_dst   = 1'b1;
                        reg_write = 1'b1;
                        alu_sft   = 1'b1;
                        alu_op    = ALU_OP_SLL;
                    end
                    FN_SAD: begin
                        reg_dst   = 1'b1;
                        reg_write = 1'b1;
                        sad_op    = 1'b1;
                        alu_op    = ALU_OP_SAD;
                    end
                    FN_JR: jr_src = 1'b1;
                    default: ;
                endcase
            end
            OP_ADDI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                alu_op    = ALU_OP_ADD;
            end
            // Loads differ only in width and sign
            OP_LW, OP_LB, OP_LH: begin
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
                alu_op     = ALU_OP_ADD;
                if (opcode == OP_LB)
                    sem_ctrl = 2'b01;
                else if (opcode == OP_LH)
                    sem_ctrl = 2'b10;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                alu_op    = ALU_OP_ADD;
            end
            OP_BEQ, OP_BNE: begin
                branch   = 1'b1;
                zero_src = (opcode == OP_BNE);
                alu_op   = ALU_OP_SUB;
            end
            OP_J: jzero_src = 1'b1;
            OP_JAL: begin
                jzero_src = 1'b1;
                reg_write = 1'b1;
                jal_src   = 1'b0;
                alu_op    = ALU_OP_LINK;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hazard_detector.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_detector (
    input  idc_pkg::reg_idx_t id_rs,
    input  idc_pkg::reg_idx_t id_rt,
    input  idc_pkg::reg_idx_t ex_rt,
    input  logic              ex_mem_read,
    output logic              hazard
);

    //////////////////////////////////////////////////
    // Load-use check against the instruction in EX
    //////////////////////////////////////////////////

    logic ex_dest_live;
    logic rs_match;
    logic rt_match;

    // A load into hardwired r0 never blocks
    assign ex_dest_live = ex_mem_read && (ex_rt != 5'd0);

    assign rs_match = (id_rs == ex_rt);
    assign rt_match = (id_rt == ex_rt);

    // Either source operand waits on the load result
    assign hazard = ex_dest_live && (rs_match || rt_match);

endmodule

`default_nettype wire

//--- control_bubble_mux.sv
`timescale 1ns/1ps
`default_nettype none

module control_bubble_mux (
    input  logic               hazard,
    input  logic               branch_flush,
    input  logic               id_alu_src,
    input  logic               id_reg_dst,
    input  logic               id_reg_write,
    input  logic               id_mem_read,
    input  logic               id_mem_write,
    input  logic               id_mem_to_reg,
    input  logic               id_alu_sft,
    input  logic               id_zero_src,
    input  logic               id_branch,
    input  logic               id_jal_src,
    input  logic               id_jzero_src,
    input  logic               id_jr_src,
    input  logic               id_sad_op,
    input  idc_pkg::alu_op_t   id_alu_op,
    input  idc_pkg::sem_ctrl_t id_sem_ctrl,
    output logic               bub_alu_src,
    output logic               bub_reg_dst,
    output logic               bub_reg_write,
    output logic               bub_mem_read,
    output logic               bub_mem_write,
    output logic               bub_mem_to_reg,
    output logic               bub_alu_sft,
    output logic               bub_zero_src,
    output logic               bub_branch,
    output logic               bub_jal_src,
    output logic               bub_jzero_src,
    output logic               bub_jr_src,
    output logic               bub_sad_op,
    output idc_pkg::alu_op_t   bub_alu_op,
    output idc_pkg::sem_ctrl_t bub_sem_ctrl
);

    import idc_pkg::*;

    logic squash;

    // Jump-and-link is never squashed
    assign squash = (hazard || branch_flush) && (id_alu_op != ALU_OP_LINK);

    // Bubble is all zero except jal_src
    assign bub_alu_src    = squash ? 1'b0 : id_alu_src;
    assign bub_reg_dst    = squash ? 1'b0 : id_reg_dst;
    assign bub_reg_write  = squash ? 1'b0 : id_reg_write;
    assign bub_mem_read   = squash ? 1'b0 : id_mem_read;
    assign bub_mem_write  = squash ? 1'b0 : id_mem_write;
    assign bub_mem_to_reg = squash ? 1'b0 : id_mem_to_reg;
    assign bub_alu_sft    = squash ? 1'b0 : id_alu_sft;
    assign bub_zero_src   = squash ? 1'b0 : id_zero_src;
    assign bub_branch     = squash ? 1'b0 : id_branch;
    assign bub_jal_src    = squash ? 1'b1 : id_jal_src;
    assign bub_jzero_src  = squash ? 1'b0 : id_jzero_src;
    assign bub_jr_src     = squash ? 1'b0 : id_jr_src;
    assign bub_sad_op     = squash ? 1'b0 : id_sad_op;
    assign bub_alu_op     = squash ? ALU_OP_NOP : id_alu_op;
    assign bub_sem_ctrl   = squash ? 2'b00 : id_sem_ctrl;

endmodule

`default_nettype wire

//--- id_ex_control_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_control_reg (
    input  logic               clk,
    input  logic               rst,
    input  logic               bub_alu_src,
    input  logic               bub_reg_dst,
    input  logic               bub_reg_write,
    input  logic               bub_mem_read,
    input  logic               bub_mem_write,
    input  logic               bub_mem_to_reg,
    input  logic               bub_alu_sft,
    input  logic               bub_zero_src,
    input  logic               bub_branch,
    input  logic               bub_jal_src,
    input  logic               bub_jzero_src,
    input  logic               bub_jr_src,
    input  logic               bub_sad_op,
    input  idc_pkg::alu_op_t   bub_alu_op,
    input  idc_pkg::sem_ctrl_t bub_sem_ctrl,
    input  idc_pkg::reg_idx_t  id_rt,
    input  idc_pkg::reg_idx_t  id_rd,
    output logic               ex_alu_src,
    output logic               ex_reg_dst,
    output logic               ex_reg_write,
    output logic               ex_mem_read,
    output logic               ex_mem_write,
    output logic               ex_mem_to_reg,
    output logic               ex_alu_sft,
    output logic               ex_zero_src,
    output logic               ex_branch,
    output logic               ex_jal_src,
    output logic               ex_jzero_src,
    output logic               ex_jr_src,
    output logic               ex_sad_op,
    output idc_pkg::alu_op_t   ex_alu_op,
    output idc_pkg::sem_ctrl_t ex_sem_ctrl,
    output idc_pkg::reg_idx_t  ex_rt,
    output idc_pkg::reg_idx_t  ex_rd
);

    import idc_pkg::*;

    //////////////////////////////////////////////////
    // ID/EX stage register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            // Reset value equals the bubble
            {ex_alu_src, ex_reg_dst, ex_reg_write}      <= 3'b000;
            {ex_mem_read, ex_mem_write, ex_mem_to_reg}  <= 3'b000;
            {ex_alu_sft, ex_zero_src, ex_branch}        <= 3'b000;
            ex_jal_src                                  <= 1'b1;
            {ex_jzero_src, ex_jr_src, ex_sad_op}        <= 3'b000;
            ex_alu_op                                   <= ALU_OP_NOP;
            ex_sem_ctrl                                 <= 2'b00;
            ex_rt                                       <= 5'd0;
            ex_rd                                       <= 5'd0;
        end else begin
            {ex_alu_src, ex_reg_dst, ex_reg_write}     <= {bub_alu_src, bub_reg_dst, bub_reg_write};
            {ex_mem_read, ex_mem_write, ex_mem_to_reg} <=
                {bub_mem_read, bub_mem_write, bub_mem_to_reg};
            {ex_alu_sft, ex_zero_src, ex_branch}       <= {bub_alu_sft, bub_zero_src, bub_branch};
            ex_jal_src                                 <= bub_jal_src;
            {ex_jzero_src, ex_jr_src, ex_sad_op}       <= {bub_jzero_src, bub_jr_src, bub_sad_op};
            ex_alu_op                                  <= bub_alu_op;
            ex_sem_ctrl                                <= bub_sem_ctrl;
            // indices follow the instruction even through a bubble
            ex_rt                                      <= id_rt;
            ex_rd                                      <= id_rd;
        end
    end

endmodule

`default_nettype wire

//--- decode_control_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_control_top (
    input  logic               clk,
    input  logic               rst,
    input  idc_pkg::instr_t    instr,
    input  logic               branch_taken,
    output logic               stall,
    output logic               ex_alu_src,
    output logic               ex_reg_dst,
    output logic               ex_reg_write,
    output logic               ex_mem_read,
    output logic               ex_mem_write,
    output logic               ex_mem_to_reg,
    output logic               ex_alu_sft,
    output logic               ex_zero_src,
    output logic               ex_branch,
    output logic               ex_jal_src,
    output logic               ex_jzero_src,
    output logic               ex_jr_src,
    output logic               ex_sad_op,
    output idc_pkg::alu_op_t   ex_alu_op,
    output idc_pkg::sem_ctrl_t ex_sem_ctrl,
    output idc_pkg::reg_idx_t  ex_rt,
    output idc_pkg::reg_idx_t  ex_rd
);

    import idc_pkg::*;

    //////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t id_rs;
    reg_idx_t id_rt;
    reg_idx_t id_rd;

    assign opcode = instr[31:26];
    assign id_rs  = instr[25:21];
    assign id_rt  = instr[20:16];
    assign id_rd  = instr[15:11];
    assign funct  = instr[5:0];

    // Raw decoder outputs
    logic      dec_alu_src, dec_reg_dst, dec_reg_write, dec_mem_read, dec_mem_write;
    logic      dec_mem_to_reg, dec_alu_sft, dec_zero_src, dec_branch, dec_jal_src;
    logic      dec_jzero_src, dec_jr_src, dec_sad_op;
    alu_op_t   dec_alu_op;
    sem_ctrl_t dec_sem_ctrl;

    // After the bubble mux
    logic      bub_alu_src, bub_reg_dst, bub_reg_write, bub_mem_read, bub_mem_write;
    logic      bub_mem_to_reg, bub_alu_sft, bub_zero_src, bub_branch, bub_jal_src;
    logic      bub_jzero_src, bub_jr_src, bub_sad_op;
    alu_op_t   bub_alu_op;
    sem_ctrl_t bub_sem_ctrl;

    logic hazard;

    // Load-use stall holds the instruction upstream
    assign stall = hazard;

    control_decoder control_decoder_i (
        .opcode     (opcode),
        .funct      (funct),
        .alu_src    (dec_alu_src),
        .reg_dst    (dec_reg_dst),
        .reg_write  (dec_reg_write),
        .mem_read   (dec_mem_read),
        .mem_write  (dec_mem_write),
        .mem_to_reg (dec_mem_to_reg),
        .alu_sft    (dec_alu_sft),
        .zero_src   (dec_zero_src),
        .branch     (dec_branch),
        .jal_src    (dec_jal_src),
        .jzero_src  (dec_jzero_src),
        .jr_src     (dec_jr_src),
        .sad_op     (dec_sad_op),
        .alu_op     (dec_alu_op),
        .sem_ctrl   (dec_sem_ctrl)
    );

    hazard_detector hazard_detector_i (
        .id_rs       (id_rs),
        .id_rt       (id_rt),
        .ex_rt       (ex_rt),
        .ex_mem_read (ex_mem_read),
        .hazard      (hazard)
    );

    control_bubble_mux control_bubble_mux_i (
        .hazard         (hazard),
        .branch_flush   (branch_taken),
        .id_alu_src     (dec_alu_src),
        .id_reg_dst     (dec_reg_dst),
        .id_reg_write   (dec_reg_write),
        .id_mem_read    (dec_mem_read),
        .id_mem_write   (dec_mem_write),
        .id_mem_to_reg  (dec_mem_to_reg),
        .id_alu_sft     (dec_alu_sft),
        .id_zero_src    (dec_zero_src),
        .id_branch      (dec_branch),
        .id_jal_src     (dec_jal_src),
        .id_jzero_src   (dec_jzero_src),
        .id_jr_src      (dec_jr_src),
        .id_sad_op      (dec_sad_op),
        .id_alu_op      (dec_alu_op),
        .id_sem_ctrl    (dec_sem_ctrl),
        .bub_alu_src    (bub_alu_src),
        .bub_reg_dst    (bub_reg_dst),
        .bub_reg_write  (bub_reg_write),
        .bub_mem_read   (bub_mem_read),
        .bub_mem_write  (bub_mem_write),
        .bub_mem_to_reg (bub_mem_to_reg),
        .bub_alu_sft    (bub_alu_sft),
        .bub_zero_src   (bub_zero_src),
        .bub_branch     (bub_branch),
        .bub_jal_src    (bub_jal_src),
        .bub_jzero_src  (bub_jzero_src),
        .bub_jr_src     (bub_jr_src),
        .bub_sad_op     (bub_sad_op),
        .bub_alu_op     (bub_alu_op),
        .bub_sem_ctrl   (bub_sem_ctrl)
    );

    id_ex_control_reg id_ex_control_reg_i (
        .clk            (clk),
        .rst            (rst),
        .bub_alu_src    (bub_alu_src),
        .bub_reg_dst    (bub_reg_dst),
        .bub_reg_write  (bub_reg_write),
        .bub_mem_read   (bub_mem_read),
        .bub_mem_write  (bub_mem_write),
        .bub_mem_to_reg (bub_mem_to_reg),
        .bub_alu_sft    (bub_alu_sft),
        .bub_zero_src   (bub_zero_src),
        .bub_branch     (bub_branch),
        .bub_jal_src    (bub_jal_src),
        .bub_jzero_src  (bub_jzero_src),
        .bub_jr_src     (bub_jr_src),
        .bub_sad_op     (bub_sad_op),
        .bub_alu_op     (bub_alu_op),
        .bub_sem_ctrl   (bub_sem_ctrl),
        .id_rt          (id_rt),
        .id_rd          (id_rd),
        .ex_alu_src     (ex_alu_src),
        .ex_reg_dst     (ex_reg_dst),
        .ex_reg_write   (ex_reg_write),
        .ex_mem_read    (ex_mem_read),
        .ex_mem_write   (ex_mem_write),
        .ex_mem_to_reg  (ex_mem_to_reg),
        .ex_alu_sft     (ex_alu_sft),
        .ex_zero_src    (ex_zero_src),
        .ex_branch      (ex_branch),
        .ex_jal_src     (ex_jal_src),
        .ex_jzero_src   (ex_jzero_src),
        .ex_jr_src      (ex_jr_src),
        .ex_sad_op      (ex_sad_op),
        .ex_alu_op      (ex_alu_op),
        .ex_sem_ctrl    (ex_sem_ctrl),
        .ex_rt          (ex_rt),
        .ex_rd          (ex_rd)
    );

endmodule

`default_nettype wire

//--- tb_decode_control.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_control;

    import idc_pkg::*;

    localparam int CLK_HALF    = 20;
    localparam int RST_CYCLES  = 16;
    localparam int RST_TIMEOUT = 64;
    localparam int MAX_ROWS    = 40;
    localparam int LIMIT_NS    = 10000;

    typedef logic [12:0] ctrl_vec_t;

    // One bit per control from alu_src at the top down to sad_op
    localparam ctrl_vec_t C_ALU_SRC    = 13'h1000;
    localparam ctrl_vec_t C_REG_DST    = 13'h0800;
    localparam ctrl_vec_t C_REG_WRITE  = 13'h0400;
    localparam ctrl_vec_t C_MEM_READ   = 13'h0200;
    localparam ctrl_vec_t C_MEM_WRITE  = 13'h0100;
    localparam ctrl_vec_t C_MEM_TO_REG = 13'h0080;
    localparam ctrl_vec_t C_ALU_SFT    = 13'h0040;
    localparam ctrl_vec_t C_ZERO_SRC   = 13'h0020;
    localparam ctrl_vec_t C_BRANCH     = 13'h0010;
    localparam ctrl_vec_t C_JAL_SRC    = 13'h0008;
    localparam ctrl_vec_t C_JZERO_SRC  = 13'h0004;
    localparam ctrl_vec_t C_JR_SRC     = 13'h0002;
    localparam ctrl_vec_t C_SAD_OP     = 13'h0001;

    // Expected control sets per instruction class
    localparam ctrl_vec_t E_BUBBLE = C_JAL_SRC;
    localparam ctrl_vec_t E_RALU   = C_REG_DST | C_REG_WRITE | C_JAL_SRC;
    localparam ctrl_vec_t E_SLL    = E_RALU | C_ALU_SFT;
    localparam ctrl_vec_t E_SAD    = E_RALU | C_SAD_OP;
    localparam ctrl_vec_t E_JR     = C_JR_SRC | C_JAL_SRC;
    localparam ctrl_vec_t E_ADDI   = C_ALU_SRC | C_REG_WRITE | C_JAL_SRC;
    localparam ctrl_vec_t E_LOAD   = E_ADDI | C_MEM_READ | C_MEM_TO_REG;
    localparam ctrl_vec_t E_STORE  = C_ALU_SRC | C_MEM_WRITE | C_JAL_SRC;
    localparam ctrl_vec_t E_BEQ    = C_BRANCH | C_JAL_SRC;
    localparam ctrl_vec_t E_BNE    = E_BEQ | C_ZERO_SRC;
    localparam ctrl_vec_t E_J      = C_JZERO_SRC | C_JAL_SRC;
    localparam ctrl_vec_t E_JAL    = C_JZERO_SRC | C_REG_WRITE;

    logic      clk;
    logic      rst;
    instr_t    instr;
    logic      branch_taken;
    logic      stall;
    logic      ex_alu_src, ex_reg_dst, ex_reg_write, ex_mem_read, ex_mem_write;
    logic      ex_mem_to_reg, ex_alu_sft, ex_zero_src, ex_branch, ex_jal_src;
    logic      ex_jzero_src, ex_jr_src, ex_sad_op;
    alu_op_t   ex_alu_op;
    sem_ctrl_t ex_sem_ctrl;
    reg_idx_t  ex_rt;
    reg_idx_t  ex_rd;

    // Stimulus table with one entry per row
    string     row_name  [MAX_ROWS];
    instr_t    row_instr [MAX_ROWS];
    logic      row_br    [MAX_ROWS];
    logic      row_stall [MAX_ROWS];
    ctrl_vec_t row_ctrl  [MAX_ROWS];
    alu_op_t   row_alu   [MAX_ROWS];
    sem_ctrl_t row_sem   [MAX_ROWS];
    reg_idx_t  row_rt    [MAX_ROWS];
    reg_idx_t  row_rd    [MAX_ROWS];
    int        n_rows;

    int    error_count;
    int    pass_count;
    int    fail_count;
    string cur_test;

    decode_control_top decode_control_top_i (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .branch_taken  (branch_taken),
        .stall         (stall),
        .ex_alu_src    (ex_alu_src),
        .ex_reg_dst    (ex_reg_dst),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_mem_to_reg (ex_mem_to_reg),
        .ex_alu_sft    (ex_alu_sft),
        .ex_zero_src   (ex_zero_src),
        .ex_branch     (ex_branch),
        .ex_jal_src    (ex_jal_src),
        .ex_jzero_src  (ex_jzero_src),
        .ex_jr_src     (ex_jr_src),
        .ex_sad_op     (ex_sad_op),
        .ex_alu_op     (ex_alu_op),
        .ex_sem_ctrl   (ex_sem_ctrl),
        .ex_rt         (ex_rt),
        .ex_rd         (ex_rd)
    );

    always #CLK_HALF clk = ~clk;

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_ctrl(input ctrl_vec_t got, input ctrl_vec_t exp);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s control set got %b expected %b",
                     $time, cur_test, got, exp);
            error_count++;
        end
    endtask

    task automatic check_alu_op(input alu_op_t got, input alu_op_t exp);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s ex_alu_op got %b expected %b",
                     $time, cur_test, got, exp);
            error_count++;
        end
    endtask

    task automatic check_sem(input sem_ctrl_t got, input sem_ctrl_t exp);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s ex_sem_ctrl got %b expected %b",
                     $time, cur_test, got, exp);
            error_count++;
        end
    endtask

    task automatic check_idx(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s %s got %0d expected %0d",
                     $time, cur_test, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s %s got %b expected %b",
                     $time, cur_test, what, got, exp);
            error_count++;
        end
    endtask

    function automatic ctrl_vec_t ex_ctrl_vec();
        return {ex_alu_src, ex_reg_dst, ex_reg_write, ex_mem_read, ex_mem_write,
                ex_mem_to_reg, ex_alu_sft, ex_zero_src, ex_branch, ex_jal_src,
                ex_jzero_src, ex_jr_src, ex_sad_op};
    endfunction

    task automatic finish_test(input int errs_before);
        if (error_count == errs_before) begin
            pass_count++;
            $display("PASS  %s", cur_test);
        end else begin
            fail_count++;
            $display("FAIL  %s", cur_test);
        end
    endtask

    //////////////////////////////////////////////////
    // Table construction
    //////////////////////////////////////////////////

    task automatic add_row(input string name, input opcode_t op, input funct_t fn,
                           input reg_idx_t rs, input reg_idx_t rt, input reg_idx_t rd,
                           input logic br, input logic stl, input ctrl_vec_t ctrl,
                           input alu_op_t alu, input sem_ctrl_t sem);
        row_name[n_rows]  = name;
        row_instr[n_rows] = {op, rs, rt, rd, 5'd0, fn};
        row_br[n_rows]    = br;
        row_stall[n_rows] = stl;
        row_ctrl[n_rows]  = ctrl;
        row_alu[n_rows]   = alu;
        row_sem[n_rows]   = sem;
        row_rt[n_rows]    = rt;
        row_rd[n_rows]    = rd;
        n_rows++;
    endtask

    // Registers 8..31 here while load rows stay within 0..7
    task automatic add_rand_row(input string name, input opcode_t op, input funct_t fn,
                                input logic br, input ctrl_vec_t ctrl, input alu_op_t alu,
                                input sem_ctrl_t sem);
        int unsigned r0;
        int unsigned r1;
        int unsigned r2;
        r0 = 8 + ($urandom % 24);
        r1 = 8 + ($urandom % 24);
        r2 = 8 + ($urandom % 24);
        add_row(name, op, fn, r0[4:0], r1[4:0], r2[4:0], br, 1'b0, ctrl, alu, sem);
    endtask

    task automatic build_table();
        // One row per decoder class
        add_rand_row("add", OP_RTYPE, FN_ADD, 1'b0, E_RALU, ALU_OP_ADD, 2'b00);
        add_rand_row("sub", OP_RTYPE, FN_SUB, 1'b0, E_RALU, ALU_OP_SUB, 2'b00);
        add_rand_row("and", OP_RTYPE, FN_AND, 1'b0, E_RALU, ALU_OP_AND, 2'b00);
        add_rand_row("or", OP_RTYPE, FN_OR, 1'b0, E_RALU, ALU_OP_OR, 2'b00);
        add_rand_row("slt", OP_RTYPE, FN_SLT, 1'b0, E_RALU, ALU_OP_SLT, 2'b00);
        add_rand_row("sll", OP_RTYPE, FN_SLL, 1'b0, E_SLL, ALU_OP_SLL, 2'b00);
        add_rand_row("sad", OP_RTYPE, FN_SAD, 1'b0, E_SAD, ALU_OP_SAD, 2'b00);
        add_rand_row("jr", OP_RTYPE, FN_JR, 1'b0, E_JR, ALU_OP_NOP, 2'b00);
        add_rand_row("addi", OP_ADDI, 6'd0, 1'b0, E_ADDI, ALU_OP_ADD, 2'b00);
        add_row("lw", OP_LW, 6'd0, 5'd2, 5'd6, 5'd0, 1'b0, 1'b0, E_LOAD, ALU_OP_ADD, 2'b00);
        add_row("lb", OP_LB, 6'd0, 5'd3, 5'd7, 5'd0, 1'b0, 1'b0, E_LOAD, ALU_OP_ADD, 2'b01);
        add_row("lh", OP_LH, 6'd0, 5'd1, 5'd6, 5'd0, 1'b0, 1'b0, E_LOAD, ALU_OP_ADD, 2'b10);
        add_rand_row("sw", OP_SW, 6'd0, 1'b0, E_STORE, ALU_OP_ADD, 2'b00);
        add_rand_row("beq", OP_BEQ, 6'd0, 1'b0, E_BEQ, ALU_OP_SUB, 2'b00);
        add_rand_row("bne", OP_BNE, 6'd0, 1'b0, E_BNE, ALU_OP_SUB, 2'b00);
        add_rand_row("j", OP_J, 6'd0, 1'b0, E_J, ALU_OP_NOP, 2'b00);
        add_rand_row("jal", OP_JAL, 6'd0, 1'b0, E_JAL, ALU_OP_LINK, 2'b00);

        // Load-use on r5, then the held ADD, then a load into r0
        add_row("lw r5", OP_LW, 6'd0, 5'd2, 5'd5, 5'd0, 1'b0, 1'b0, E_LOAD, ALU_OP_ADD, 2'b00);
        add_row("add stalled", OP_RTYPE, FN_ADD, 5'd5, 5'd3, 5'd4, 1'b0, 1'b1,
                E_BUBBLE, ALU_OP_NOP, 2'b00);
        add_row("add held", OP_RTYPE, FN_ADD, 5'd5, 5'd3, 5'd4, 1'b0, 1'b0,
                E_RALU, ALU_OP_ADD, 2'b00);
        add_row("lw r0", OP_LW, 6'd0, 5'd2, 5'd0, 5'd0, 1'b0, 1'b0, E_LOAD, ALU_OP_ADD, 2'b00);
        add_row("add r0", OP_RTYPE, FN_ADD, 5'd0, 5'd0, 5'd4, 1'b0, 1'b0,
                E_RALU, ALU_OP_ADD, 2'b00);

        // Same load-use through the rt operand
        add_row("lw r6", OP_LW, 6'd0, 5'd2, 5'd6, 5'd0, 1'b0, 1'b0, E_LOAD, ALU_OP_ADD, 2'b00);
        add_row("sub rt stalled", OP_RTYPE, FN_SUB, 5'd1, 5'd6, 5'd4, 1'b0, 1'b1,
                E_BUBBLE, ALU_OP_NOP, 2'b00);
        add_row("sub rt held", OP_RTYPE, FN_SUB, 5'd1, 5'd6, 5'd4, 1'b0, 1'b0,
                E_RALU, ALU_OP_SUB, 2'b00);

        // Branch flush, then link under flush and under load-use
        add_rand_row("addi flushed", OP_ADDI, 6'd0, 1'b1, E_BUBBLE, ALU_OP_NOP, 2'b00);
        add_rand_row("addi kept", OP_ADDI, 6'd0, 1'b0, E_ADDI, ALU_OP_ADD, 2'b00);
        add_rand_row("jal flush", OP_JAL, 6'd0, 1'b1, E_JAL, ALU_OP_LINK, 2'b00);
        add_row("lw r5 again", OP_LW, 6'd0, 5'd2, 5'd5, 5'd0, 1'b0, 1'b0,
                E_LOAD, ALU_OP_ADD, 2'b00);
        add_row("jal load-use", OP_JAL, 6'd0, 5'd5, 5'd1, 5'd31, 1'b0, 1'b1,
                E_JAL, ALU_OP_LINK, 2'b00);
    endtask

    //////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////

    task automatic wait_reset_release(output bit ok);
        int cycles;
        cycles = 0;
        while (rst !== 1'b0 && cycles < RST_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = (rst === 1'b0);
    endtask

    task automatic apply_rows();
        int   i;
        int   errs_before;
        logic stall_seen;
        @(posedge clk);
        #2;
        for (i = 0; i < n_rows; i++) begin
            instr        = row_instr[i];
            branch_taken = row_br[i];
            // Mid-cycle once the decode path has settled
            #20;
            stall_seen = stall;
            @(posedge clk);
            #1;
            cur_test    = row_name[i];
            errs_before = error_count;
            check_bit(stall_seen, row_stall[i], "stall");
            check_ctrl(ex_ctrl_vec(), row_ctrl[i]);
            check_alu_op(ex_alu_op, row_alu[i]);
            check_sem(ex_sem_ctrl, row_sem[i]);
            check_idx(ex_rt, row_rt[i], "ex_rt");
            check_idx(ex_rd, row_rd[i], "ex_rd");
            finish_test(errs_before);
            #1;
        end
    endtask

    initial begin
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    end

    initial begin
        #LIMIT_NS;
        $display("Simulation ran past its time limit of %0d ns", LIMIT_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        bit          rst_ok;
        int unsigned seed_draw;
        int          errs_before;
        clk          = 1'b0;
        rst          = 1'b1;
        instr        = '0;
        branch_taken = 1'b0;
        n_rows       = 0;
        error_count  = 0;
        pass_count   = 0;
        fail_count   = 0;
        cur_test     = "setup";
        seed_draw    = $urandom(32'h0c9e_7581);
        build_table();

        wait_reset_release(rst_ok);
        if (!rst_ok) begin
            $display("Reset was never released within %0d cycles", RST_TIMEOUT);
            fail_count++;
        end else begin
            // Register still holds its reset value here
            cur_test    = "reset state";
            errs_before = error_count;
            check_ctrl(ex_ctrl_vec(), E_BUBBLE);
            check_alu_op(ex_alu_op, ALU_OP_NOP);
            check_sem(ex_sem_ctrl, 2'b00);
            check_idx(ex_rt, 5'd0, "ex_rt");
            check_idx(ex_rd, 5'd0, "ex_rd");
            finish_test(errs_before);
            apply_rows();
        end

        $display("Tests: %0d passed, %0d failed, %0d mismatches",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
idc_pkg.sv
control_decoder.sv
hazard_detector.sv
control_bubble_mux.sv
id_ex_control_reg.sv
decode_control_top.sv
tb_decode_control.sv

//--- Bender.yml
package:
  name: decode_control

sources:
  - idc_pkg.sv
  - control_decoder.sv
  - hazard_detector.sv
  - control_bubble_mux.sv
  - id_ex_control_reg.sv
  - decode_control_top.sv
  - target: test
    files:
      - tb_decode_control.sv
